// File: Makefile
# Verilator simulation of the stuffer output subsystem
TOP       ?= tb_stuffer_output
FILELIST  ?= stuffer_output.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/bit_stuffer_metadata.sv
// metadata stage: forwards data words and closes each frame with padding, metadata and zeros
`timescale 1ns/1ps

module bit_stuffer_metadata (
    input  logic                 xclk,
    input  logic                 xrst,
    input  logic                 last_block,  // rising edge fetches the timestamp
    input  logic                 ts_pre_stb,
    input  stuffer_pkg::byte_t   ts_data,
    input  logic                 frame_start, // falling edge starts the frame
    input  stuffer_pkg::word_t   din,
    input  stuffer_pkg::nbytes_t bytes_in,
    input  logic                 in_stb,
    input  logic                 flush,
    input  logic                 abort,       // rising edge forces a flush
    output stuffer_pkg::word_t   data_out,
    output logic                 data_out_valid,
    output logic                 done,
    output logic                 running
);
    import stuffer_pkg::*;

    trl_state_t state;
    logic [2:0] trl_idx;      // word index within meta or zero section
    wcount_t    wcnt;         // words sent in this frame
    word_t      size_word;
    word_t      ts_word [2];  // seconds, microseconds
    word_t      meta_word;
    byte_t      ts_dout;
    logic [2:0] ts_idx;
    logic [3:0] ts_in;        // readout window, bit 3 set when idle
    logic       frame_start_d;
    logic       last_block_d;
    logic       abort_r;
    logic       abort_d;
    logic       force_flush;
    logic       trl_end;      // last zero word on the output
    logic       stb_start;
    logic       ts_rstb;
    logic       trailer;
    logic       trl_start;
    logic       accept;
    logic       at_slot;
    logic       pad_last;
    logic       meta_last;
    logic       zero_last;

    assign stb_start = frame_start_d && !frame_start;
    assign ts_rstb   = last_block && !last_block_d;
    assign trailer   = (state == TRL_PAD) || (state == TRL_META) || (state == TRL_ZERO);
    assign trl_start = (flush || force_flush) && !trailer;
    assign accept    = in_stb && !trailer && !force_flush; // data dropped once trailer runs
    assign at_slot   = (wcnt % TRAILER_ALIGN) == META_SLOT;
    assign pad_last  = ((wcnt + 1) % TRAILER_ALIGN) == META_SLOT;
    assign meta_last = (state == TRL_META) && (trl_idx == 3'(META_WORDS - 1));
    assign zero_last = (state == TRL_ZERO) && (trl_idx == 3'(ZERO_WORDS - 1));

    always_comb begin
        case (trl_idx)
            3'd0:    meta_word = ts_word[0];
            3'd1:    meta_word = ts_word[1];
            3'd2:    meta_word = size_word;
            default: meta_word = '0;
        endcase
    end

    // timestamp bytes arrive LSB first, LSB lands in the high lane
    always_ff @(posedge xclk) begin
        if (!ts_in[3]) ts_word[ts_idx[2]][31 - 8 * int'(ts_idx[1:0]) -: 8] <= ts_dout;
    end

    // size: word count, last byte count, 0xff marker
    always_ff @(posedge xclk) begin
        if (xrst || zero_last) size_word <= {22'd0, 2'd0, 8'hff};
        else if (accept)       size_word <= {wcount_t'(wcnt + 1'b1), bytes_in, 8'hff};
    end

    always_ff @(posedge xclk) begin
        if (accept)                 data_out <= din;
        else if (state == TRL_META) data_out <= meta_word;
        else                        data_out <= '0; // pad and closing zeros
    end

    always_ff @(posedge xclk) begin
        if (xrst) begin
            state          <= TRL_IDLE;
            trl_idx        <= '0;
            wcnt           <= '0;
            ts_in          <= 4'd8;
            frame_start_d  <= 1'b0;
            last_block_d   <= 1'b0;
            abort_r        <= 1'b0;
            abort_d        <= 1'b0;
            force_flush    <= 1'b0;
            data_out_valid <= 1'b0;
            trl_end        <= 1'b0;
            done           <= 1'b0;
            running        <= 1'b0;
        end else begin
            frame_start_d <= frame_start;
            last_block_d  <= last_block;
            abort_r       <= abort;
            abort_d       <= abort_r;
            force_flush   <= abort_r && !abort_d && !trailer; // ignored once trailer began
            if (ts_rstb)         ts_in <= '0;
            else if (!ts_in[3])  ts_in <= ts_in + 4'd1;
            if (zero_last)                wcnt <= '0;
            else if (accept || trailer)   wcnt <= wcnt + 1'b1;
            case (state)
                TRL_IDLE, TRL_DATA: begin
                    trl_idx <= '0;
                    if (trl_start)               state <= at_slot ? TRL_META : TRL_PAD;
                    else if (accept || stb_start) state <= TRL_DATA;
                end
                TRL_PAD: begin
                    if (pad_last) state <= TRL_META;
                end
                TRL_META: begin
                    trl_idx <= meta_last ? 3'd0 : trl_idx + 3'd1;
                    if (meta_last) state <= TRL_ZERO;
                end
                TRL_ZERO: begin
                    trl_idx <= trl_idx + 3'd1;
                    if (zero_last) state <= TRL_IDLE;
                end
                default: state <= TRL_IDLE;
            endcase
            data_out_valid <= accept || trailer;
            trl_end        <= zero_last;
            done           <= trl_end;
            if (trl_start)      running <= 1'b0;
            else if (stb_start) running <= 1'b1;
        end
    end

    timestamp_fifo i_timestamp_fifo (
        .xclk     (xclk),
        .xrst     (xrst),
        .pre_stb  (ts_pre_stb),
        .din      (ts_data),
        .advance  (stb_start), // frame start commits its timestamp
        .rstb     (ts_rstb),
        .dout     (ts_dout),
        .dout_idx (ts_idx)
    );

    // upstream stays quiet between flush and done
    a_no_data_in_meta: assert property (@(posedge xclk) disable iff (xrst)
        (state == TRL_META) |-> !in_stb)
        else $error("data word during metadata");

    a_done_pulse: assert property (@(posedge xclk) disable iff (xrst) done |=> !done)
        else $error("done longer than one cycle");

endmodule

// File: source/byte_stuffer.sv
// byte stuffer that escapes 0xff with a 0x00 and packs the byte stream MSB first into words
`timescale 1ns/1ps

module byte_stuffer (
    input  logic                 xclk,
    input  logic                 xrst,
    input  stuffer_pkg::byte_t   byte_in,
    input  logic                 byte_valid,
    input  logic                 byte_flush, // after last byte of the frame
    output stuffer_pkg::word_t   din,        // packed word MSB aligned
    output stuffer_pkg::nbytes_t bytes_in,   // valid bytes where 0 means 4
    output logic                 in_stb,
    output logic                 flush
);
    import stuffer_pkg::*;

    word_t       sr;         // collected bytes left aligned
    logic [1:0]  cnt;        // bytes held in sr
    logic        pend;       // 0x00 owed for an 0xff that closed a word
    logic        flush_pend; // flush due after the partial word
    logic [63:0] acc;        // sr plus bytes appended this cycle
    logic [2:0]  fill;       // bytes in acc up to 5
    logic        emit;

    // append owed zero, new byte and its escape zero
    always_comb begin
        acc  = {sr, 32'h0};
        fill = {1'b0, cnt};
        if (pend) begin
            acc[63 - 8 * int'(fill) -: 8] = 8'h00;
            fill = fill + 3'd1;
        end
        if (byte_valid) begin
            acc[63 - 8 * int'(fill) -: 8] = byte_in;
            fill = fill + 3'd1;
            if (byte_in == ESC_BYTE) begin
                acc[63 - 8 * int'(fill) -: 8] = 8'h00;
                fill = fill + 3'd1;
            end
        end
    end

    // full word or the remainder at end of frame
    assign emit = fill[2] || (byte_flush && (fill != 3'd0));

    // word and byte count towards the metadata stage
    always_ff @(posedge xclk) begin
        if (emit) begin
            din      <= acc[63:32];
            bytes_in <= fill[2] ? nbytes_t'(0) : fill[1:0];
        end
    end

    always_ff @(posedge xclk) begin
        if (xrst) begin
            sr         <= '0;
            cnt        <= '0;
            pend       <= 1'b0;
            in_stb     <= 1'b0;
            flush_pend <= 1'b0;
            flush      <= 1'b0;
        end else begin
            in_stb <= emit;
            if (fill[2] || byte_flush) begin
                sr  <= '0; // start a fresh word
                cnt <= '0;
            end else begin
                sr  <= acc[63:32];
                cnt <= fill[1:0];
            end
            // only an escape zero can spill past a full word
            pend       <= (fill == 3'd5);
            flush_pend <= byte_flush && (fill != 3'd0);
            flush      <= flush_pend || (byte_flush && (fill == 3'd0));
        end
    end

    // byte_flush is sent only once the last byte has gone
    a_flush_alone: assert property (@(posedge xclk) disable iff (xrst)
        byte_flush |-> !byte_valid)
        else $error("byte_valid together with byte_flush");

endmodule

// File: source/stuffer_output.sv
// stuffer output top: byte stuffer feeding the metadata and trailer stage
`timescale 1ns/1ps

module stuffer_output (
    input  logic               xclk,
    input  logic               xrst,
    input  stuffer_pkg::byte_t byte_in,
    input  logic               byte_valid,
    input  logic               byte_flush,
    input  logic               ts_pre_stb,
    input  stuffer_pkg::byte_t ts_data,
    input  logic               frame_start,
    input  logic               last_block,
    input  logic               abort,
    output stuffer_pkg::word_t data_out,
    output logic               data_out_valid,
    output logic               done,
    output logic               running
);
    import stuffer_pkg::*;

    word_t   din;      // packed stream word
    nbytes_t bytes_in; // its byte count
    logic    in_stb;
    logic    flush;    // after final word of the frame

    byte_stuffer i_byte_stuffer (
        .xclk       (xclk),
        .xrst       (xrst),
        .byte_in    (byte_in),
        .byte_valid (byte_valid),
        .byte_flush (byte_flush),
        .din        (din),
        .bytes_in   (bytes_in),
        .in_stb     (in_stb),
        .flush      (flush)
    );

    bit_stuffer_metadata i_bit_stuffer_metadata (
        .xclk           (xclk),
        .xrst           (xrst),
        .last_block     (last_block),
        .ts_pre_stb     (ts_pre_stb),
        .ts_data        (ts_data),
        .frame_start    (frame_start),
        .din            (din),
        .bytes_in       (bytes_in),
        .in_stb         (in_stb),
        .flush          (flush),
        .abort          (abort),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .done           (done),
        .running        (running)
    );

endmodule

// File: source/stuffer_pkg.sv
// stuffer package: shared vector types, trailer states and frame layout constants
package stuffer_pkg;

    // vector types
    typedef logic [7:0]  byte_t;   // stream byte or timestamp byte
    typedef logic [31:0] word_t;   // output word, MSB aligned
    typedef logic [1:0]  nbytes_t; // valid bytes in a word, 0 means 4
    typedef logic [21:0] wcount_t; // image size in 4-byte words

    // trailer sequencer
    typedef enum logic [2:0] {
        TRL_IDLE, // between frames
        TRL_DATA, // frame data flowing
        TRL_PAD,  // zero words up to the metadata slot
        TRL_META, // seconds, microseconds, size, zero
        TRL_ZERO  // closing zero words
    } trl_state_t;

    // timestamp layout
    localparam int TS_BYTES = 8; // 4 bytes seconds, 4 bytes microseconds, LSB first
    localparam int TS_DEPTH = 2; // frames buffered between start and last block

    // trailer layout
    localparam int TRAILER_ALIGN = 8; // frame length granule in words
    localparam int META_SLOT     = 4; // word count mod align where metadata begins
    localparam int META_WORDS    = 4;
    localparam int ZERO_WORDS    = 8;

    // escape value, always followed by 0x00 in the output
    localparam byte_t ESC_BYTE = 8'hff;

endpackage

// File: source/timestamp_fifo.sv
// timestamp queue: captures 8-byte frame timestamps and replays the oldest one byte by byte
`timescale 1ns/1ps

module timestamp_fifo (
    input  logic               xclk,
    input  logic               xrst,
    input  logic               pre_stb,  // one cycle ahead of 8 timestamp bytes
    input  stuffer_pkg::byte_t din,
    input  logic               advance,  // commit captured timestamp
    input  logic               rstb,     // start readout of oldest entry
    output stuffer_pkg::byte_t dout,
    output logic [2:0]         dout_idx  // byte number of dout
);
    import stuffer_pkg::*;

    byte_t                       cap [TS_BYTES];            // capture buffer
    byte_t                       ring [TS_DEPTH][TS_BYTES]; // committed timestamps
    logic [3:0]                  cap_idx;                   // bit 3 set when idle
    logic [3:0]                  rd_idx;                    // bit 3 set when idle
    logic [$clog2(TS_DEPTH)-1:0] wr_ptr;
    logic [$clog2(TS_DEPTH)-1:0] rd_ptr;
    logic [$clog2(TS_DEPTH):0]   fill;                      // entries held
    logic                        rd_hit;                    // readout started on a real entry
    logic                        full;
    logic                        push;
    logic                        pop;

    assign full = (fill == TS_DEPTH);
    assign push = advance && !full;
    assign pop  = (rd_idx == 4'd7) && rd_hit && !rstb; // last byte leaving, free entry

    // capture and ring storage
    always_ff @(posedge xclk) begin
        if (!cap_idx[3]) cap[cap_idx[2:0]] <= din;
        if (push) begin
            for (int i = 0; i < TS_BYTES; i++) begin
                ring[wr_ptr][i] <= cap[i]; // whole timestamp at once
            end
        end
    end

    // readout, zeros when nothing was queued
    always_ff @(posedge xclk) begin
        if (rstb) begin
            dout     <= (fill != 0) ? ring[rd_ptr][0] : '0;
            dout_idx <= '0;
        end else if (!rd_idx[3]) begin
            dout     <= rd_hit ? ring[rd_ptr][rd_idx[2:0]] : '0;
            dout_idx <= rd_idx[2:0];
        end
    end

    always_ff @(posedge xclk) begin
        if (xrst) begin
            cap_idx <= 4'd8;
            rd_idx  <= 4'd8;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            rd_hit  <= 1'b0;
        end else begin
            if (pre_stb)          cap_idx <= '0;
            else if (!cap_idx[3]) cap_idx <= cap_idx + 4'd1;
            if (rstb) begin
                rd_idx <= 4'd1; // byte 0 goes out right away
                rd_hit <= (fill != 0);
            end else if (!rd_idx[3]) begin
                rd_idx <= rd_idx + 4'd1;
            end
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + push - pop;
        end
    end

    // producer must not commit into a full ring
    a_no_overrun: assert property (@(posedge xclk) disable iff (xrst) advance |-> !full)
        else $error("timestamp queue overrun");

endmodule

// File: stuffer_output.f
+incdir+verif
source/stuffer_pkg.sv
source/timestamp_fifo.sv
source/byte_stuffer.sv
source/bit_stuffer_metadata.sv
source/stuffer_output.sv
verif/tb_stuffer_output.sv

// File: verif/stuffer_model.svh
// reference model: expected escaped data words and trailer of one frame
`ifndef STUFFER_MODEL_SVH
`define STUFFER_MODEL_SVH

typedef byte_t byte_q_t[$];
typedef word_t word_q_t[$];

// every escape byte gets a 0x00 behind it
function automatic byte_q_t escape_stream(byte_q_t src);
    byte_q_t dst;
    foreach (src[i]) begin
        dst.push_back(src[i]);
        if (src[i] == ESC_BYTE) dst.push_back(8'h00); // stuffed zero
    end
    return dst;
endfunction

// n bytes starting at first, first byte in the high lane
function automatic word_t pack_lanes(byte_q_t s, int first, int n);
    word_t w;
    int    k;
    w = '0; // unused low lanes stay zero
    for (k = 0; k < n; k++) begin
        w[31 - 8 * k -: 8] = s[first + k];
    end
    return w;
endfunction

// data words, pad to the metadata slot, metadata, closing zeros
function automatic word_q_t expected_frame(byte_q_t src, byte_q_t ts, bit aborted);
    byte_q_t s;
    word_q_t w;
    word_t   size;
    nbytes_t last_nb;
    int      k;
    s       = escape_stream(src);
    last_nb = '0; // full last word reads as 0
    for (k = 0; k + 4 <= s.size(); k += 4) begin
        w.push_back(pack_lanes(s, k, 4));
    end
    // an abort never sees the partial word, a flush sends it left aligned
    if (!aborted && (s.size() % 4) != 0) begin
        w.push_back(pack_lanes(s, k, s.size() % 4));
        last_nb = nbytes_t'(s.size() % 4);
    end
    size = {wcount_t'(w.size()), last_nb, 8'hff}; // data words only
    while ((w.size() % TRAILER_ALIGN) != META_SLOT) w.push_back('0);
    w.push_back(pack_lanes(ts, 0, 4)); // seconds, lsb first
    w.push_back(pack_lanes(ts, 4, 4)); // microseconds
    w.push_back(size);
    for (k = 3; k < META_WORDS + ZERO_WORDS; k++) begin
        w.push_back('0); // last meta word and closing zeros
    end
    return w;
endfunction

`endif

// File: verif/tb_stuffer_output.sv
// testbench for the stuffer output top with random frames ending in flush or abort
`timescale 1ns/1ps

module tb_stuffer_output;
    import stuffer_pkg::*;

    `include "stuffer_model.svh"

    localparam int HALF_PERIOD  = 50;  // 100 ns clock
    localparam int RESET_CYCLES = 16;
    localparam int N_FRAMES     = 6;
    localparam int TOTAL_BYTES  = 149; // sum of the frame lengths below

    logic    xclk;
    logic    xrst;
    byte_t   byte_in;
    logic    byte_valid;
    logic    byte_flush;
    logic    ts_pre_stb;
    byte_t   ts_data;
    logic    frame_start;
    logic    last_block;
    logic    abort;
    word_t   data_out;
    logic    data_out_valid;
    logic    done;
    logic    running;
    integer  seed;
    int      frames_seen;  // done pulses so far
    word_q_t exp_words;    // expected output of all queued frames
    wcount_t exp_len [$];  // expected words per frame

    stuffer_output i_stuffer_output (
        .xclk           (xclk),
        .xrst           (xrst),
        .byte_in        (byte_in),
        .byte_valid     (byte_valid),
        .byte_flush     (byte_flush),
        .ts_pre_stb     (ts_pre_stb),
        .ts_data        (ts_data),
        .frame_start    (frame_start),
        .last_block     (last_block),
        .abort          (abort),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .done           (done),
        .running        (running)
    );

    always #HALF_PERIOD xclk = ~xclk;

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(word_t got, word_t want);
        if (got !== want) begin
            $display("MISMATCH %0t: data_out %h, expected %h", $time, got, want);
            stop_on_failure();
        end
    endtask

    task automatic check_done(wcount_t got, wcount_t want);
        if (got !== want || (got % TRAILER_ALIGN) != 0) begin
            $display("MISMATCH %0t: %0d words before done, expected %0d in 8-word units",
                     $time, got, want);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(logic got, logic want, string what);
        if (got !== want) begin
            $display("MISMATCH %0t: %s is %b, expected %b", $time, what, got, want);
            stop_on_failure();
        end
    endtask

    // random bytes free of 0xff or three in four 0xff
    function automatic byte_q_t make_bytes(int n, bit mostly_esc);
        byte_q_t q;
        byte_t   b;
        repeat (n) begin
            b = byte_t'($random(seed));
            if (mostly_esc && ($random(seed) & 3) != 0) b = ESC_BYTE;
            else if (!mostly_esc && b == ESC_BYTE) b = 8'h7e;
            q.push_back(b);
        end
        return q;
    endfunction

    task automatic run_frame(int n, bit mostly_esc, bit aborted);
        byte_q_t src;
        byte_q_t ts;
        word_q_t exp;
        int      target;
        src    = make_bytes(n, mostly_esc);
        ts     = make_bytes(TS_BYTES, 1'b0);
        exp    = expected_frame(src, ts, aborted);
        target = frames_seen + 1;
        exp_len.push_back(wcount_t'(exp.size()));
        foreach (exp[i]) exp_words.push_back(exp[i]);
        @(posedge xclk);
        ts_pre_stb <= 1'b1; // 8 timestamp bytes follow
        foreach (ts[i]) begin
            @(posedge xclk);
            ts_pre_stb <= 1'b0;
            ts_data    <= ts[i];
        end
        @(posedge xclk);
        frame_start <= 1'b1;
        @(posedge xclk);
        frame_start <= 1'b0; // falling edge queues the timestamp
        repeat (2) @(negedge xclk);
        check_flag(running, 1'b1, "running in frame");
        foreach (src[i]) begin
            @(posedge xclk);
            byte_in    <= src[i];
            byte_valid <= 1'b1;
        end
        @(posedge xclk);
        byte_valid <= 1'b0;
        last_block <= 1'b1; // replays oldest timestamp
        @(posedge xclk);
        last_block <= 1'b0;
        repeat (12) @(posedge xclk); // 8-byte readout settles
        @(negedge xclk);
        check_flag(running, 1'b1, "running before end of frame");
        @(posedge xclk);
        if (aborted) abort <= 1'b1;
        else byte_flush <= 1'b1;
        @(posedge xclk);
        abort      <= 1'b0;
        byte_flush <= 1'b0;
        wait (frames_seen == target);
    endtask

    // outputs sampled on the falling edge
    initial begin : compare_outputs
        int seen;
        seen = 0;
        forever begin
            @(negedge xclk);
            if (data_out_valid === 1'b1) begin
                if (exp_words.size() == 0) begin
                    $display("output word %h at %0t with nothing expected", data_out, $time);
                    stop_on_failure();
                end else begin
                    check_word(data_out, exp_words.pop_front());
                    seen++;
                end
            end
            if (done === 1'b1) begin
                if (exp_len.size() == 0) begin
                    $display("done pulse at %0t with no frame in progress", $time);
                    stop_on_failure();
                end else begin
                    check_done(wcount_t'(seen), exp_len.pop_front());
                    check_flag(running, 1'b0, "running at done");
                    seen = 0;
                    frames_seen++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + 4 * TOTAL_BYTES + 64 * N_FRAMES) @(posedge xclk);
        $display("timeout, frames did not finish in time");
        stop_on_failure();
    end

    initial begin
        xclk        = 1'b0;
        xrst        = 1'b1;
        byte_in     = '0;
        byte_valid  = 1'b0;
        byte_flush  = 1'b0;
        ts_pre_stb  = 1'b0;
        ts_data     = '0;
        frame_start = 1'b0;
        last_block  = 1'b0;
        abort       = 1'b0;
        seed        = 32'h24e01d0d;
        frames_seen = 0;
        repeat (RESET_CYCLES) @(posedge xclk);
        xrst <= 1'b0;
        @(negedge xclk);
        check_flag(running, 1'b0, "running after reset");
        check_flag(data_out_valid, 1'b0, "data_out_valid after reset");
        run_frame(24, 1'b0, 1'b0); // plain bytes in whole words
        run_frame(37, 1'b1, 1'b0); // mostly escape bytes
        run_frame(23, 1'b0, 1'b0); // partial last word
        run_frame(16, 1'b0, 1'b0); // two frames back to back
        run_frame(30, 1'b1, 1'b0);
        run_frame(19, 1'b0, 1'b1); // aborted frame leaves a partial word in the stuffer
        repeat (20) @(posedge xclk); // room for a stray done
        if (exp_words.size() != 0 || frames_seen != N_FRAMES) begin
            $display("run ended with expected words or frames outstanding");
            stop_on_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
